/* design/bus_op_pkg.sv */
package bus_op_pkg;

	typedef enum logic [2:0] {
		READB  = 3'd0, // sign-extended byte
		READBU = 3'd1, // zero-extended byte
		READH  = 3'd2, // sign-extended halfword
		READHU = 3'd3, // zero-extended halfword
		READW  = 3'd4,
		WRITEB = 3'd5,
		WRITEH = 3'd6,
		WRITEW = 3'd7
	} bus_op_t;

	typedef enum logic [2:0] {
		IDLE         = 3'd0,
		READ_START   = 3'd1,
		READ_FINISH  = 3'd2,
		WRITE_START  = 3'd3,
		WRITE_FINISH = 3'd4
	} wb8_state_t;

	// index of the last byte of a transfer
	function automatic logic [1:0] op_last_byte(bus_op_t op);
		case (op)
			READB, READBU, WRITEB: return 2'd0;
			READH, READHU, WRITEH: return 2'd1;
			default:               return 2'd3;
		endcase
	endfunction

	function automatic logic op_is_write(bus_op_t op);
		return op inside {WRITEB, WRITEH, WRITEW};
	endfunction

	function automatic logic op_signed(bus_op_t op);
		return op inside {READB, READH}; // word reads need no extension
	endfunction

endpackage

/* design/bus_wb8.sv */
`timescale 1ns/1ps

module bus_wb8 (
	input  logic                  CLK_I,
	input  logic                  RST_I,
	input  logic                  en,
	input  bus_op_pkg::bus_op_t   op,
	input  logic [31:0]           addr,
	input  logic [31:0]           wdata,
	output logic [31:0]           rdata,
	output logic                  busy,
	input  logic                  ACK_I,
	input  logic [7:0]            DAT_I,
	output logic [31:0]           ADR_O,
	output logic [7:0]            DAT_O,
	output logic                  CYC_O,
	output logic                  STB_O,
	output logic                  WE_O
);

	import bus_op_pkg::*;

	wb8_state_t  state;
	logic [1:0]  bytecnt;
	logic [1:0]  last_byte;
	logic        sign_ext;
	logic        rd_sign;
	logic [31:0] buffer;

	assign rdata = buffer;
	assign rd_sign = DAT_I[7] & sign_ext; // fill bit for bytes 0 and 1

	// control path freezes whenever en is low
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state <= IDLE;
			busy <= 1'b0;
			CYC_O <= 1'b0;
			STB_O <= 1'b0;
			WE_O <= 1'b0;
			bytecnt <= 2'd0;
		end else if (en) begin
			case (state)
				IDLE: begin
					busy <= 1'b1;
					bytecnt <= 2'd0;
					state <= op_is_write(op) ? WRITE_START : READ_START;
				end

				READ_START: begin
					WE_O <= 1'b0;
					CYC_O <= 1'b1;
					STB_O <= 1'b1;
					state <= READ_FINISH;
				end

				READ_FINISH: begin
					if (ACK_I) begin
						STB_O <= 1'b0;
						if (bytecnt < last_byte) begin
							bytecnt <= bytecnt + 2'd1;
							state <= READ_START;
						end else begin
							busy <= 1'b0;
							CYC_O <= 1'b0;
							bytecnt <= 2'd0;
							state <= IDLE;
						end
					end
				end

				WRITE_START: begin
					WE_O <= 1'b1;
					CYC_O <= 1'b1;
					STB_O <= 1'b1;
					state <= WRITE_FINISH;
				end

				WRITE_FINISH: begin
					if (ACK_I) begin
						WE_O <= 1'b0;
						STB_O <= 1'b0;
						if (bytecnt < last_byte) begin
							bytecnt <= bytecnt + 2'd1;
							state <= WRITE_START;
						end else begin
							busy <= 1'b0;
							CYC_O <= 1'b0;
							bytecnt <= 2'd0;
							state <= IDLE;
						end
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

	// data path
	always_ff @(posedge CLK_I) begin
		if (en) begin
			ADR_O <= addr + 32'(bytecnt); // byte k at addr+k
			if (state == IDLE) begin
				last_byte <= op_last_byte(op);
				sign_ext <= op_signed(op);
			end
			if (state == WRITE_START)
				DAT_O <= wdata[8*bytecnt +: 8]; // little-endian lane
			if (state == READ_FINISH && ACK_I) begin
				case (bytecnt)
					2'd0: buffer <= {{24{rd_sign}}, DAT_I};
					2'd1: buffer[31:8] <= {{16{rd_sign}}, DAT_I};
					2'd2: buffer[23:16] <= DAT_I;
					2'd3: buffer[31:24] <= DAT_I;
				endcase
			end
		end
	end

	a_stb_in_cyc: assert property (@(posedge CLK_I) disable iff (RST_I)
		STB_O |-> CYC_O);

endmodule

/* design/cpu_mem_sys.sv */
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module cpu_mem_sys (
	input  logic                 CLK_I,
	input  logic                 RST_I,
	input  logic                 en,
	input  bus_op_pkg::bus_op_t  op,
	input  logic [31:0]          addr,
	input  logic [31:0]          wdata,
	output logic [31:0]          rdata,
	output logic                 busy
);

	import wb_map_pkg::*;

	// adapter to decoder
	logic [31:0] wb_adr;
	logic [7:0]  wb_dat_w;
	logic [7:0]  wb_dat_r;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic        wb_ack;

	// decoder to slaves
	logic [`WB_SLAVES-1:0] slv_stb;
	win_off_t              slv_adr;
	logic                  slv_we;
	logic [7:0]            slv_dat;
	logic [`WB_SLAVES-1:0] slv_ack;
	logic [7:0]            slv_rdat [`WB_SLAVES];

	bus_wb8 u_bus (
		.CLK_I(CLK_I), .RST_I(RST_I),
		.en(en), .op(op), .addr(addr), .wdata(wdata),
		.rdata(rdata), .busy(busy),
		.ACK_I(wb_ack), .DAT_I(wb_dat_r),
		.ADR_O(wb_adr), .DAT_O(wb_dat_w), .CYC_O(wb_cyc), .STB_O(wb_stb), .WE_O(wb_we)
	);

	wb8_decoder u_dec (
		.CLK_I(CLK_I), .RST_I(RST_I),
		.ADR_I(wb_adr), .DAT_I(wb_dat_w), .CYC_I(wb_cyc), .STB_I(wb_stb), .WE_I(wb_we),
		.ACK_O(wb_ack), .DAT_O(wb_dat_r),
		.slv_stb(slv_stb), .slv_adr(slv_adr), .slv_we(slv_we), .slv_dat(slv_dat),
		.slv_ack(slv_ack), .slv_rdat(slv_rdat)
	);

	for (genvar i = 0; i < `WB_SLAVES; i++) begin : g_ram
		wb8_ram u_ram (
			.CLK_I(CLK_I), .RST_I(RST_I),
			.stb(slv_stb[i]), .we(slv_we), .adr(slv_adr), .wdat(slv_dat),
			.ack(slv_ack[i]), .rdat(slv_rdat[i])
		);
	end

endmodule

/* design/mem_sys_consts.svh */
`ifndef MEM_SYS_CONSTS_SVH
`define MEM_SYS_CONSTS_SVH

// number of byte-wide RAM slaves on the bus
`define WB_SLAVES 4

// log2 of one slave window in bytes
`define WB_WIN_BITS 8

// cycles a RAM slave waits before ack (minimum 1)
`define WB_WAIT 1

// read value for an address outside every window
`define WB_UNMAPPED_DATA 8'hFF

`endif

/* design/wb8_decoder.sv */
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module wb8_decoder (
	input  logic                   CLK_I,
	input  logic                   RST_I,
	input  logic [31:0]            ADR_I,
	input  logic [7:0]             DAT_I,
	input  logic                   CYC_I,
	input  logic                   STB_I,
	input  logic                   WE_I,
	output logic                   ACK_O,
	output logic [7:0]             DAT_O,
	output logic [`WB_SLAVES-1:0]  slv_stb,
	output wb_map_pkg::win_off_t   slv_adr,
	output logic                   slv_we,
	output logic [7:0]             slv_dat,
	input  logic [`WB_SLAVES-1:0]  slv_ack,
	input  logic [7:0]             slv_rdat [`WB_SLAVES]
);

	import wb_map_pkg::*;

	slave_idx_t sel;
	logic       mapped;
	logic       un_ack; // default responder

	assign mapped = addr_mapped(ADR_I);
	assign sel = addr_slave(ADR_I);

	assign slv_adr = addr_offset(ADR_I);
	assign slv_we = WE_I;
	assign slv_dat = DAT_I;

	always_comb begin
		slv_stb = '0;
		if (CYC_I && STB_I && mapped)
			slv_stb[sel] = 1'b1; // unmapped writes go nowhere
	end

	// one-cycle ack one cycle after the strobe
	always_ff @(posedge CLK_I) begin
		if (RST_I)
			un_ack <= 1'b0;
		else
			un_ack <= CYC_I && STB_I && !mapped && !un_ack;
	end

	assign ACK_O = mapped ? slv_ack[sel] : un_ack;
	assign DAT_O = mapped ? slv_rdat[sel] : `WB_UNMAPPED_DATA;

	a_one_slave: assert property (@(posedge CLK_I) disable iff (RST_I)
		$onehot0(slv_stb));

	// an answer only ever meets a live strobe
	a_ack_in_stb: assert property (@(posedge CLK_I) disable iff (RST_I)
		ACK_O |-> CYC_I && STB_I);

endmodule

/* design/wb8_ram.sv */
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module wb8_ram (
	input  logic                  CLK_I,
	input  logic                  RST_I,
	input  logic                  stb,
	input  logic                  we,
	input  wb_map_pkg::win_off_t  adr,
	input  logic [7:0]            wdat,
	output logic                  ack,
	output logic [7:0]            rdat
);

	localparam int WAIT_LAST = (`WB_WAIT > 0) ? `WB_WAIT - 1 : 0;
	localparam int CNT_W = $clog2(WAIT_LAST + 2);

	logic [7:0]       mem [2**`WB_WIN_BITS];
	logic [CNT_W-1:0] cnt;
	logic             done; // acked and waiting for stb to drop
	logic             fire;

	assign fire = stb && !done && (cnt == CNT_W'(WAIT_LAST));

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			ack <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else begin
			ack <= fire;
			if (!stb) begin
				done <= 1'b0;
				cnt <= '0;
			end else if (fire) begin
				done <= 1'b1;
			end else if (!done) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// read data lands with ack and a write commits on the same edge
	always_ff @(posedge CLK_I) begin
		if (fire) begin
			if (we)
				mem[adr] <= wdat;
			rdat <= mem[adr];
		end
	end

	a_ack_pulse: assert property (@(posedge CLK_I) disable iff (RST_I)
		ack |=> !ack);

endmodule

/* design/wb_map_pkg.sv */
`include "mem_sys_consts.svh"

package wb_map_pkg;

	localparam int IDX_BITS = $clog2(`WB_SLAVES);

	typedef logic [IDX_BITS-1:0] slave_idx_t;
	typedef logic [`WB_WIN_BITS-1:0] win_off_t;

	// mapped only when nothing is set above the slave index
	function automatic logic addr_mapped(logic [31:0] a);
		return a[31:`WB_WIN_BITS+IDX_BITS] == '0;
	endfunction

	function automatic slave_idx_t addr_slave(logic [31:0] a);
		return a[`WB_WIN_BITS +: IDX_BITS];
	endfunction

	function automatic win_off_t addr_offset(logic [31:0] a);
		return a[`WB_WIN_BITS-1:0];
	endfunction

endpackage

/* files.f */
+incdir+design
design/bus_op_pkg.sv
design/wb_map_pkg.sv
design/bus_wb8.sv
design/wb8_decoder.sv
design/wb8_ram.sv
design/cpu_mem_sys.sv
sim/tb_cpu_mem_sys.sv

/* sim/tb_cpu_mem_sys.sv */
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module tb_cpu_mem_sys;

	import bus_op_pkg::*;

	localparam int MAPPED = `WB_SLAVES << `WB_WIN_BITS;
	localparam int WAIT_LIMIT = 100; // cycles allowed per wait

	logic        CLK_I;
	logic        RST_I;
	logic        en;
	bus_op_t     op;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        busy;

	logic [7:0]  ref_mem [MAPPED]; // reference copy of the mapped bytes
	logic [31:0] lfsr;
	string       cur_test;
	int          test_errs;
	int          pass_cnt;
	int          fail_cnt;

	cpu_mem_sys u_dut (
		.CLK_I(CLK_I), .RST_I(RST_I),
		.en(en), .op(op), .addr(addr), .wdata(wdata),
		.rdata(rdata), .busy(busy)
	);

	always begin
		CLK_I = 1'b0;
		#4;
		CLK_I = 1'b1;
		#4;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[31]};
		end
	endtask

	function automatic logic [31:0] fill_word(logic [31:0] a);
		return (a * 32'h0100_0193) ^ 32'h5a3c_96e1;
	endfunction

	function automatic int op_bytes(bus_op_t o);
		case (o)
			READB, READBU, WRITEB: return 1;
			READH, READHU, WRITEH: return 2;
			default:               return 4;
		endcase
	endfunction

	function automatic logic [7:0] model_byte(logic [31:0] a);
		return (a < MAPPED) ? ref_mem[a] : `WB_UNMAPPED_DATA;
	endfunction

	task automatic model_write(input bus_op_t o, input logic [31:0] a, input logic [31:0] d);
		for (int k = 0; k < op_bytes(o); k++)
			if (a + 32'(k) < MAPPED)
				ref_mem[a + 32'(k)] = d[8*k +: 8]; // unmapped bytes are dropped
	endtask

	// little-endian assembly with extension from the top received byte
	function automatic logic [31:0] model_read(bus_op_t o, logic [31:0] a);
		logic [7:0] b [4];
		for (int k = 0; k < 4; k++)
			b[k] = model_byte(a + 32'(k));
		case (o)
			READB:   return {{24{b[0][7]}}, b[0]};
			READBU:  return {24'h0, b[0]};
			READH:   return {{16{b[1][7]}}, b[1], b[0]};
			READHU:  return {16'h0, b[1], b[0]};
			default: return {b[3], b[2], b[1], b[0]};
		endcase
	endfunction

	task automatic abort_run(input string why);
		$display("%s within %0d cycles during test %s", why, WAIT_LIMIT, cur_test);
		$display("tests failed");
		$finish;
	endtask

	task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("** Error %s: %s expected %08h, actual %08h", cur_test, what, exp, got);
			test_errs++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			pass_cnt++;
			$display("test %s: ok", cur_test);
		end else begin
			fail_cnt++;
			$display("test %s: %0d mismatches", cur_test, test_errs);
		end
	endtask

	// holds en until busy has risen and fallen again
	task automatic run_op(input bus_op_t o, input logic [31:0] a, input logic [31:0] d,
			output logic [31:0] r);
		int n;
		@(posedge CLK_I);
		#1;
		en = 1'b1;
		op = o;
		addr = a;
		wdata = d;
		n = 0;
		while (!busy) begin
			@(posedge CLK_I);
			#1;
			n++;
			if (n > WAIT_LIMIT)
				abort_run("busy did not rise");
		end
		n = 0;
		while (busy) begin
			@(posedge CLK_I);
			#1;
			n++;
			if (n > WAIT_LIMIT)
				abort_run("busy did not fall");
		end
		en = 1'b0;
		r = rdata;
		if (o inside {WRITEB, WRITEH, WRITEW})
			model_write(o, a, d);
	endtask

	task automatic write_op(input bus_op_t o, input logic [31:0] a, input logic [31:0] d);
		logic [31:0] r;
		run_op(o, a, d, r);
	endtask

	task automatic read_expect(input bus_op_t o, input logic [31:0] a, input logic [31:0] exp);
		logic [31:0] r;
		run_op(o, a, 32'h0, r);
		expect_eq($sformatf("%s @%08h", o.name(), a), exp, r);
	endtask

	task automatic read_check(input bus_op_t o, input logic [31:0] a);
		read_expect(o, a, model_read(o, a));
	endtask

	initial begin
		logic [31:0] v;
		logic [31:0] a;
		logic [31:0] d;
		RST_I = 1'b1;
		en = 1'b0;
		op = READW;
		addr = 32'h0;
		wdata = 32'h0;
		lfsr = 32'h69bcc77c;
		pass_cnt = 0;
		fail_cnt = 0;
		repeat (3) @(posedge CLK_I);
		#1;
		RST_I = 1'b0;

		begin_test("reset");
		expect_eq("busy", 32'd0, {31'd0, busy});
		end_test();

		// RAM powers up undefined, so give every mapped byte a known value
		cur_test = "preload";
		for (int w = 0; w < MAPPED; w += 4)
			write_op(WRITEW, 32'(w), fill_word(32'(w)));
		$display("preload: %0d bytes written", MAPPED);

		begin_test("word round trip");
		write_op(WRITEW, 32'h0000_0040, 32'hdead_beef);
		read_expect(READW, 32'h0000_0040, 32'hdead_beef);
		write_op(WRITEW, 32'h0000_00fe, 32'h1234_5678); // crosses slave 0 into 1
		read_expect(READW, 32'h0000_00fe, 32'h1234_5678);
		write_op(WRITEW, 32'h0000_02fd, 32'hcafe_f00d);
		read_expect(READW, 32'h0000_02fd, 32'hcafe_f00d);
		end_test();

		begin_test("extension");
		write_op(WRITEW, 32'h0000_0180, 32'h01ff_7f80); // bytes 80 7f ff 01
		read_expect(READB,  32'h0000_0180, 32'hffff_ff80);
		read_expect(READBU, 32'h0000_0180, 32'h0000_0080);
		read_expect(READH,  32'h0000_0180, 32'h0000_7f80);
		read_expect(READHU, 32'h0000_0180, 32'h0000_7f80);
		read_expect(READB,  32'h0000_0181, 32'h0000_007f);
		read_expect(READH,  32'h0000_0181, 32'hffff_ff7f);
		read_expect(READHU, 32'h0000_0181, 32'h0000_ff7f);
		read_expect(READB,  32'h0000_0182, 32'hffff_ffff);
		read_expect(READBU, 32'h0000_0182, 32'h0000_00ff);
		read_expect(READH,  32'h0000_0182, 32'h0000_01ff);
		read_expect(READHU, 32'h0000_0182, 32'h0000_01ff);
		end_test();

		begin_test("partial writes");
		write_op(WRITEW, 32'h0000_0260, 32'h1122_3344);
		write_op(WRITEB, 32'h0000_0261, 32'h5555_55aa);
		read_check(READW, 32'h0000_0260);
		write_op(WRITEH, 32'h0000_0262, 32'h6666_bbcc);
		read_check(READW, 32'h0000_0260);
		read_check(READW, 32'h0000_025c); // neighbours untouched
		read_check(READW, 32'h0000_0264);
		end_test();

		begin_test("unmapped");
		read_expect(READW,  32'h0000_0400, 32'hffff_ffff);
		read_expect(READB,  32'h0001_0000, 32'hffff_ffff);
		read_expect(READBU, 32'h8000_0123, 32'h0000_00ff);
		write_op(WRITEW, 32'h0000_0404, 32'h0000_0000);
		for (int w = 0; w < MAPPED; w += 4)
			read_check(READW, 32'(w));
		end_test();

		begin_test("random traffic");
		for (int i = 0; i < 40; i++) begin
			rand_bits(3, v);
			rand_bits(10, a);
			rand_bits(32, d);
			if (bus_op_t'(v[2:0]) inside {WRITEB, WRITEH, WRITEW})
				write_op(bus_op_t'(v[2:0]), a, d);
			else
				read_check(bus_op_t'(v[2:0]), a);
		end
		end_test();

		$display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
